// ==== verilog/vlc_pkg.sv ====
package vlc_pkg;

	////////////////////////////////////////////////////////////
	// Table dimensions
	////////////////////////////////////////////////////////////

	// Deflate limit on code length
	localparam int MAX_BITS    = 15;
	localparam int SYMBOL_W    = 8;
	localparam int NUM_SYMBOLS = 1 << SYMBOL_W;
	localparam int BL_COUNT_W  = 9;

	// Entry fields, MSB first: length, overflow, code
	localparam int LEN_W       = 4;
	localparam int CODE_W      = 15;
	localparam int ENTRY_W     = LEN_W + 1 + CODE_W;

	////////////////////////////////////////////////////////////
	// Types
	////////////////////////////////////////////////////////////

	// Length 0 marks an illegal entry
	typedef logic [LEN_W-1:0]      code_len_t;
	typedef logic [BL_COUNT_W-1:0] bl_count_t;
	typedef logic [SYMBOL_W-1:0]   symbol_t;

	// Top bit is the carry out of the 15-bit code, i.e. overflow
	typedef logic [CODE_W:0]       next_code_t;

	typedef logic [ENTRY_W-1:0]    vlc_entry_t;

	// Controller states
	typedef enum logic [2:0]
	{
		IDLE,
		NEXT_CODE_INIT,
		BLCNT_SEEK,
		HEAP_READ,
		VLC_GEN,
		DONE
	} gen_state_t;

endpackage

// ==== verilog/next_code_calc.sv ====
`timescale 1ns/1ns

module next_code_calc import vlc_pkg::*;
(
	input  logic       clk,
	input  logic       rstN,
	// One step per init_en cycle, count of the previous length
	input  logic       init_en,
	input  bl_count_t  init_count,
	// Read side
	input  code_len_t  nc_len,
	output next_code_t next_code
);

	// Length the next step writes
	code_len_t  step_idx;
	// next_code of the length written last
	next_code_t acc;
	next_code_t step_value;
	next_code_t nc_reg [1:MAX_BITS];

	////////////////////////////////////////////////////////////
	// Step value
	////////////////////////////////////////////////////////////

	// next_code[1] is always zero, whatever count comes in
	always_comb
	begin
		if (step_idx == code_len_t'(1))
			step_value = '0;
		else
			step_value = (acc + next_code_t'(init_count)) << 1;
	end

	////////////////////////////////////////////////////////////
	// Step index
	////////////////////////////////////////////////////////////

	// Back to length 1 as soon as a step run ends
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			step_idx <= code_len_t'(1);
		else if (init_en)
			step_idx <= step_idx + code_len_t'(1);
		else
			step_idx <= code_len_t'(1);
	end

	// Accumulator and per-length registers
	always_ff @(posedge clk)
	begin
		if (init_en)
		begin
			acc <= step_value;
			nc_reg[step_idx] <= step_value;
		end
	end

	// Length 0 has no code
	always_comb
	begin
		if (nc_len == '0)
			next_code = '0;
		else
			next_code = nc_reg[nc_len];
	end

endmodule

// ==== verilog/code_assigner.sv ====
`timescale 1ns/1ns

module code_assigner import vlc_pkg::*;
(
	input  logic       clk,
	input  logic       rstN,
	// Host handshake
	input  logic       start,
	output logic       done,
	// Histogram table, combinational read
	output code_len_t  bl_cnt_addr,
	input  bl_count_t  bl_cnt_data,
	// Heap FIFO, data follows the read by one cycle
	input  logic       heap_empty,
	output logic       heap_rd,
	input  symbol_t    heap_sym,
	// next_code block
	output logic       init_en,
	output bl_count_t  init_count,
	output code_len_t  nc_len,
	input  next_code_t next_code,
	// VLC table
	output logic       tbl_clear,
	output logic       tbl_we,
	output symbol_t    tbl_waddr,
	output vlc_entry_t tbl_wdata,
	output logic       lookup_en
);

	gen_state_t state;
	gen_state_t next_state;

	// Length under scan, also the init walk index
	code_len_t  scan_len;
	// Symbols left at this length
	bl_count_t  sub_cnt;
	// Code for the next symbol, counts down
	next_code_t code_cnt;

	logic       start_ok;
	logic       last_len;
	logic       seek_hit;

	assign start_ok = start && ((state == IDLE) || (state == DONE));
	assign last_len = (scan_len == code_len_t'(MAX_BITS));
	assign seek_hit = (bl_cnt_data != '0);

	////////////////////////////////////////////////////////////
	// FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			state <= IDLE;
		else
			state <= next_state;
	end

	always_comb
	begin
		next_state = state;
		case (state)
			IDLE, DONE:
				if (start)
					next_state = NEXT_CODE_INIT;
			NEXT_CODE_INIT:
				if (last_len)
					next_state = BLCNT_SEEK;
			BLCNT_SEEK:
			begin
				if (seek_hit)
					next_state = HEAP_READ;
				else if (last_len)
					next_state = DONE;
			end
			HEAP_READ:
				// Hold while the FIFO is empty
				if (!heap_empty)
					next_state = VLC_GEN;
			VLC_GEN:
			begin
				if (sub_cnt > bl_count_t'(1))
					next_state = HEAP_READ;
				else if (last_len)
					next_state = DONE;
				else
					next_state = BLCNT_SEEK;
			end
			default:
				next_state = IDLE;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Counters
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			scan_len <= code_len_t'(1);
			sub_cnt  <= '0;
			code_cnt <= '0;
		end
		else if (start_ok)
		begin
			scan_len <= code_len_t'(1);
			sub_cnt  <= '0;
			code_cnt <= '0;
		end
		else
		begin
			case (state)
				NEXT_CODE_INIT:
					// Rewind for the seek once all lengths are stored
					scan_len <= last_len ? code_len_t'(1) : scan_len + code_len_t'(1);
				BLCNT_SEEK:
				begin
					if (seek_hit)
					begin
						sub_cnt  <= bl_cnt_data;
						// Highest code first, the FIFO gives lowest length first
						code_cnt <= next_code + next_code_t'(bl_cnt_data) - next_code_t'(1);
					end
					else if (!last_len)
						scan_len <= scan_len + code_len_t'(1);
				end
				VLC_GEN:
				begin
					sub_cnt  <= sub_cnt - bl_count_t'(1);
					code_cnt <= code_cnt - next_code_t'(1);
					if ((sub_cnt == bl_count_t'(1)) && !last_len)
						scan_len <= scan_len + code_len_t'(1);
				end
				default:
					scan_len <= scan_len;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Outputs
	////////////////////////////////////////////////////////////

	// Init reads the count one length below the one being stored
	assign bl_cnt_addr = (state == NEXT_CODE_INIT) ? scan_len - code_len_t'(1) : scan_len;

	assign init_en    = (state == NEXT_CODE_INIT);
	assign init_count = bl_cnt_data;
	assign nc_len     = scan_len;

	assign heap_rd    = (state == HEAP_READ) && !heap_empty;

	assign tbl_clear  = start_ok;
	assign tbl_we     = (state == VLC_GEN);
	assign tbl_waddr  = heap_sym;
	assign tbl_wdata  = {scan_len, code_cnt};

	assign done       = (state == DONE);
	assign lookup_en  = (state == DONE);

endmodule

// ==== verilog/vlc_table.sv ====
`timescale 1ns/1ns

module vlc_table import vlc_pkg::*;
(
	input  logic       clk,
	input  logic       rstN,
	// Write side
	input  logic       tbl_clear,
	input  logic       tbl_we,
	input  symbol_t    tbl_waddr,
	input  vlc_entry_t tbl_wdata,
	// Lookup side
	input  logic       lookup_en,
	input  symbol_t    lookup_addr_a,
	input  symbol_t    lookup_addr_b,
	output vlc_entry_t lookup_data_a,
	output vlc_entry_t lookup_data_b
);

	vlc_entry_t             mem [NUM_SYMBOLS];
	logic [NUM_SYMBOLS-1:0] valid;

	// Unwritten entries read as zero, i.e. length 0
	function automatic vlc_entry_t read_entry(input symbol_t addr);
		if (lookup_en && valid[addr])
			return mem[addr];
		else
			return '0;
	endfunction

	////////////////////////////////////////////////////////////
	// Storage
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (tbl_we)
			mem[tbl_waddr] <= tbl_wdata;
	end

	// Whole vector empties in one cycle at run start
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			valid <= '0;
		else if (tbl_clear)
			valid <= '0;
		else if (tbl_we)
			valid[tbl_waddr] <= 1'b1;
	end

	////////////////////////////////////////////////////////////
	// Registered lookups
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			lookup_data_a <= '0;
			lookup_data_b <= '0;
		end
		else
		begin
			lookup_data_a <= read_entry(lookup_addr_a);
			lookup_data_b <= read_entry(lookup_addr_b);
		end
	end

endmodule

// ==== verilog/vlc_table_gen.sv ====
`timescale 1ns/1ns

module vlc_table_gen import vlc_pkg::*;
(
	input  logic       clk,
	input  logic       rstN,
	// Host handshake
	input  logic       start,
	output logic       done,
	// Histogram table
	output code_len_t  bl_cnt_addr,
	input  bl_count_t  bl_cnt_data,
	// Heap FIFO
	input  logic       heap_empty,
	output logic       heap_rd,
	input  symbol_t    heap_sym,
	// Lookup ports
	input  symbol_t    lookup_addr_a,
	input  symbol_t    lookup_addr_b,
	output vlc_entry_t lookup_data_a,
	output vlc_entry_t lookup_data_b
);

	// Controller to next_code block
	logic       init_en;
	bl_count_t  init_count;
	code_len_t  nc_len;
	next_code_t next_code;

	// Controller to table
	logic       tbl_clear;
	logic       tbl_we;
	symbol_t    tbl_waddr;
	vlc_entry_t tbl_wdata;
	logic       lookup_en;

	////////////////////////////////////////////////////////////
	// Instances
	////////////////////////////////////////////////////////////

	code_assigner u_code_assigner
	(
		.clk         (clk),
		.rstN        (rstN),
		.start       (start),
		.done        (done),
		.bl_cnt_addr (bl_cnt_addr),
		.bl_cnt_data (bl_cnt_data),
		.heap_empty  (heap_empty),
		.heap_rd     (heap_rd),
		.heap_sym    (heap_sym),
		.init_en     (init_en),
		.init_count  (init_count),
		.nc_len      (nc_len),
		.next_code   (next_code),
		.tbl_clear   (tbl_clear),
		.tbl_we      (tbl_we),
		.tbl_waddr   (tbl_waddr),
		.tbl_wdata   (tbl_wdata),
		.lookup_en   (lookup_en)
	);

	next_code_calc u_next_code_calc
	(
		.clk        (clk),
		.rstN       (rstN),
		.init_en    (init_en),
		.init_count (init_count),
		.nc_len     (nc_len),
		.next_code  (next_code)
	);

	vlc_table u_vlc_table
	(
		.clk           (clk),
		.rstN          (rstN),
		.tbl_clear     (tbl_clear),
		.tbl_we        (tbl_we),
		.tbl_waddr     (tbl_waddr),
		.tbl_wdata     (tbl_wdata),
		.lookup_en     (lookup_en),
		.lookup_addr_a (lookup_addr_a),
		.lookup_addr_b (lookup_addr_b),
		.lookup_data_a (lookup_data_a),
		.lookup_data_b (lookup_data_b)
	);

endmodule

// ==== verification/vlc_table_gen_assertions.sv ====
`timescale 1ns/1ns

module vlc_table_gen_assertions import vlc_pkg::*;
(
	input logic      clk,
	input logic      rstN,
	input logic      done,
	input logic      heap_empty,
	input logic      heap_rd,
	input logic      init_en,
	input code_len_t bl_cnt_addr
);

	// FIFO read only while it holds data
	heap_rd_has_data: assert property (@(posedge clk) disable iff (!rstN)
		heap_rd |-> !heap_empty)
		else $error("heap_rd high while heap_empty is high");

	// No FIFO traffic once the table is finished
	done_without_rd: assert property (@(posedge clk) disable iff (!rstN)
		!(done && heap_rd))
		else $error("done and heap_rd high in the same cycle");

	// Init reads lengths 0 to 14 and all other states 1 to 15
	bl_addr_in_range: assert property (@(posedge clk) disable iff (!rstN)
		init_en ? (bl_cnt_addr < code_len_t'(MAX_BITS)) : (bl_cnt_addr != '0))
		else $error("bl_cnt_addr outside the histogram range");

endmodule

bind vlc_table_gen vlc_table_gen_assertions u_assertions
(
	.clk         (clk),
	.rstN        (rstN),
	.done        (done),
	.heap_empty  (heap_empty),
	.heap_rd     (heap_rd),
	.init_en     (init_en),
	.bl_cnt_addr (bl_cnt_addr)
);

// ==== verification/vlc_table_gen_tb.sv ====
`timescale 1ns/1ns

module vlc_table_gen_tb import vlc_pkg::*;
();

	logic       clk;
	logic       rstN;
	logic       start;
	logic       done;
	code_len_t  bl_cnt_addr;
	bl_count_t  bl_cnt_data;
	logic       heap_empty = 1'b1;
	logic       heap_rd;
	symbol_t    heap_sym = '0;
	symbol_t    lookup_addr_a;
	symbol_t    lookup_addr_b;
	vlc_entry_t lookup_data_a;
	vlc_entry_t lookup_data_b;

	// Trace words and read pointer
	logic [15:0]      trace [256];
	logic [7:0]       trace_idx = '0;

	// Histogram table and heap FIFO models
	bl_count_t [15:0] bl_mem;
	symbol_t          fifo_mem [256];
	int               fifo_rd = 0;
	int               fifo_cnt = 0;
	logic             gaps_on = 1'b0;

	// Expected table, zero where the run writes nothing
	vlc_entry_t       exp_tbl [256];

	int               cycle_cnt = 0;
	int               cycle_limit = 20;

	vlc_table_gen uut
	(
		.clk           (clk),
		.rstN          (rstN),
		.start         (start),
		.done          (done),
		.bl_cnt_addr   (bl_cnt_addr),
		.bl_cnt_data   (bl_cnt_data),
		.heap_empty    (heap_empty),
		.heap_rd       (heap_rd),
		.heap_sym      (heap_sym),
		.lookup_addr_a (lookup_addr_a),
		.lookup_addr_b (lookup_addr_b),
		.lookup_data_a (lookup_data_a),
		.lookup_data_b (lookup_data_b)
	);

	// Histogram answers in the same cycle
	assign bl_cnt_data = bl_mem[bl_cnt_addr];

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt > cycle_limit)
			abort_run($sformatf("Timeout after %0d cycles, done never came", cycle_cnt));
	end

	////////////////////////////////////////////////////////////
	// Heap FIFO, data one cycle after the read
	////////////////////////////////////////////////////////////

	always @(posedge clk)
	begin
		// New run replays the FIFO from the top
		if (start)
			fifo_rd = 0;
		else if (heap_rd)
		begin
			heap_sym <= fifo_mem[symbol_t'(fifo_rd)];
			fifo_rd = fifo_rd + 1;
		end
		heap_empty <= (fifo_rd >= fifo_cnt) || (gaps_on && ($urandom % 4 == 0));
	end

	////////////////////////////////////////////////////////////
	// Tasks
	////////////////////////////////////////////////////////////

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Test FAILED");
		$fatal(1);
	endtask

	task automatic compare_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
			abort_run($sformatf("Fail %s: got %h, expected %h", name, actual, expected));
	endtask

	function automatic logic [15:0] next_trace_word();
		next_trace_word = trace[trace_idx];
		trace_idx = trace_idx + 8'd1;
	endfunction

	task automatic wait_for_done();
		while (done !== 1'b1)
			@(negedge clk);
	endtask

	// Both ports in one pass, B walks down from the top
	task automatic sweep_lookups();
		int i;
		for (i = 0; i <= NUM_SYMBOLS; i++)
		begin
			@(posedge clk);
			if (i < NUM_SYMBOLS)
			begin
				lookup_addr_a <= symbol_t'(i);
				lookup_addr_b <= symbol_t'(255 - i);
			end
			@(negedge clk);
			if (i > 0)
			begin
				compare_value($sformatf("lookup_data_a[%02h]", i - 1), 32'(lookup_data_a),
					32'(exp_tbl[symbol_t'(i - 1)]));
				compare_value($sformatf("lookup_data_b[%02h]", 256 - i), 32'(lookup_data_b),
					32'(exp_tbl[symbol_t'(256 - i)]));
			end
		end
		compare_value("done", 32'(done), 1);
	endtask

	task automatic run_trace_test();
		logic [15:0]      gaps_w;
		logic [15:0]      sym_w;
		logic [15:0]      len_w;
		logic [15:0]      ovf_w;
		logic [15:0]      code_w;
		bl_count_t [15:0] counts;
		int               n_sym;
		int               n_exp;
		int               i;

		counts = '0;
		gaps_w = next_trace_word();
		for (i = 1; i <= MAX_BITS; i++)
			counts[code_len_t'(i)] = bl_count_t'(next_trace_word());
		n_sym = int'(next_trace_word());
		for (i = 0; i < n_sym; i++)
			fifo_mem[symbol_t'(i)] = symbol_t'(next_trace_word());
		for (i = 0; i < NUM_SYMBOLS; i++)
			exp_tbl[symbol_t'(i)] = '0;
		n_exp = int'(next_trace_word());
		for (i = 0; i < n_exp; i++)
		begin
			sym_w  = next_trace_word();
			len_w  = next_trace_word();
			ovf_w  = next_trace_word();
			code_w = next_trace_word();
			// Length, overflow, low 15 code bits
			exp_tbl[symbol_t'(sym_w)] = {len_w[3:0], ovf_w[0], code_w[14:0]};
		end
		fifo_cnt = n_sym;
		gaps_on  = gaps_w[0];
		// init + seek, reads and writes, stalls, lookup sweep
		cycle_limit = cycle_limit + 30 + 3 * n_sym + (gaps_on ? 4 * n_sym : 0) + 320;

		@(posedge clk);
		bl_mem <= counts;
		start  <= 1'b1;
		@(posedge clk);
		start  <= 1'b0;
		@(negedge clk);
		// done drops for the new run
		compare_value("done", 32'(done), 0);
		wait_for_done();
		sweep_lookups();
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////

	initial
	begin
		int n_tests;
		int t;

		void'($urandom(2134));
		rstN          = 1'b0;
		start         = 1'b0;
		lookup_addr_a = '0;
		lookup_addr_b = '0;
		bl_mem        = '0;
		$readmemh("verification/vlc_trace.txt", trace);

		repeat (5) @(posedge clk);
		rstN <= 1'b1;
		@(negedge clk);
		// Quiet after reset
		compare_value("done", 32'(done), 0);
		compare_value("heap_rd", 32'(heap_rd), 0);
		compare_value("lookup_data_a", 32'(lookup_data_a), 0);
		compare_value("lookup_data_b", 32'(lookup_data_b), 0);

		n_tests = int'(next_trace_word());
		for (t = 0; t < n_tests; t++)
			run_trace_test();

		$display("Test OK");
		$finish;
	end

endmodule

// ==== verification/vlc_trace.txt ====
// Hex word stream. First word: test count. Per test: gaps flag, bl_count[1..15],
// symbol count, heap symbols in read order, entry count, then per entry: sym len ovf code
3
// Small alphabet, no FIFO stalls
0
0 1 5 2 0 0 0 0 0 0 0 0 0 0 0
8
46 41 42 43 44 45 47 48
8
46 2 0 0000
41 3 0 0006
42 3 0 0005
43 3 0 0004
44 3 0 0003
45 3 0 0002
47 4 0 000f
48 4 0 000e
// Lengths 1 to 15 with random stalls, table edges 00 and ff
1
1 1 0 2 0 0 1 0 0 0 0 0 0 0 2
7
10 20 30 31 40 ff 00
7
10 1 0 0000
20 2 0 0002
30 4 0 000d
31 4 0 000c
40 7 0 0070
ff f 0 7101
00 f 0 7100
// Over-subscribed histogram, length 15 carries into bit 15
1
2 0 0 0 0 0 0 1 0 0 0 0 0 0 2
5
05 06 80 81 82
5
05 1 0 0001
06 1 0 0000
80 8 0 0100
81 f 1 0081
82 f 1 0080

// ==== vlc_table_gen.f ====
verilog/vlc_pkg.sv
verilog/next_code_calc.sv
verilog/code_assigner.sv
verilog/vlc_table.sv
verilog/vlc_table_gen.sv
verification/vlc_table_gen_assertions.sv
verification/vlc_table_gen_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Run from the project root
verilator --binary --timing --assert --top-module vlc_table_gen_tb -f vlc_table_gen.f \
	&& ./obj_dir/Vvlc_table_gen_tb | grep "Test OK" \
	|| { echo "Simulation did not pass"; exit 1; }
